/* hdl/audio_pkg.sv */
`default_nettype none

package audio_pkg;

	// microphone and speaker sample width
	localparam int SAMPLE_W = 16;

	// click shape
	localparam logic signed [SAMPLE_W-1:0] IMPULSE_AMP = 16'sd16000;
	localparam int IMPULSE_LEN = 4; // samples per click

endpackage

`default_nettype wire

/* hdl/ranging_pkg.sv */
`default_nettype none

package ranging_pkg;

	// round controller states
	typedef enum logic [2:0] {
		IDLE,
		START,
		AWAIT_CLICK,
		ANALYZE,
		REARM
	} ranger_state_t;

	localparam int DELAY_W = 12; // delay in 24 kHz samples
	localparam int ENERGY_W = 40; // window energy sum

	// give up on a round after this many samples
	localparam int MAX_DELAY = 512;
	// strobes to wait between rounds
	localparam int REARM_STEPS = 32;

	// last_two after a timed out round
	localparam logic [23:0] SENTINEL_PAIR = 24'hDEAD_BE;

	// 343 m/s / 24 kHz / 2 = 0.7146 cm in Q8
	localparam logic [7:0] CM_PER_STEP_Q8 = 8'd183;
	localparam int DIST_W = 16;

endpackage

`default_nettype wire

/* hdl/impulse_generator.sv */
`default_nettype none

module impulse_generator import audio_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic impulse_in,
	output logic impulse_out,
	output logic signed [SAMPLE_W-1:0] amp_out
);

	logic armed; // click requested, waiting for next sample strobe
	logic [$clog2(IMPULSE_LEN+1)-1:0] remaining; // click samples still to play

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			armed <= 1'b0;
			remaining <= '0;
			impulse_out <= 1'b0;
			amp_out <= '0;
		end else begin
			impulse_out <= 1'b0;
			if (impulse_in) begin
				armed <= 1'b1;
			end
			if (step_in) begin
				if (armed) begin
					// first click sample marks the delay origin
					armed <= 1'b0;
					amp_out <= IMPULSE_AMP;
					remaining <= $bits(remaining)'(IMPULSE_LEN - 1);
					impulse_out <= 1'b1;
				end else if (remaining != '0) begin
					amp_out <= -amp_out; // alternate polarity
					remaining <= remaining - 1'b1;
				end else begin
					amp_out <= '0; // silence after the click
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/onset_detector.sv */
`default_nettype none

// windowed energy onset test
// window j is an onset when E(j) > E(j-1) and E(j) > 1.25 * E(j-2)
module onset_detector import audio_pkg::*, ranging_pkg::*; #(
	parameter int WINDOW_SIZE = 16
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic clear,
	input logic enable,
	input logic signed [SAMPLE_W-1:0] mic_in,
	output logic window_end,
	output logic onset
);

	logic signed [SAMPLE_W:0] mic_ext;
	logic [SAMPLE_W:0] mic_abs; // one extra bit for -32768

	logic [ENERGY_W-1:0] cur_sum; // running sum of current window
	logic [ENERGY_W-1:0] prev_sum; // window j-1
	logic [ENERGY_W-1:0] prev_prev_sum; // window j-2
	logic [ENERGY_W-1:0] sum_next;
	logic [ENERGY_W:0] prev_prev_thresh;

	logic [$clog2(WINDOW_SIZE+1)-1:0] win_idx;

	assign mic_ext = {mic_in[SAMPLE_W-1], mic_in};
	assign mic_abs = mic_ext[SAMPLE_W] ? -mic_ext : mic_ext;

	// sum including the sample on this strobe
	assign sum_next = cur_sum + ENERGY_W'(mic_abs);

	// 1.25 * E(j-2) widened so a maximal history does not wrap
	assign prev_prev_thresh = {1'b0, prev_prev_sum} + (ENERGY_W+1)'(prev_prev_sum >> 2);

	assign window_end = enable & step_in &
		(win_idx == $bits(win_idx)'(WINDOW_SIZE - 1));

	assign onset = window_end & (sum_next > prev_sum) &
		({1'b0, sum_next} > prev_prev_thresh);

	always_ff @(posedge clk_in) begin
		if (rst_in || clear) begin
			win_idx <= '0;
			cur_sum <= '0;
			// windows before window 0 look maximal
			prev_sum <= '1;
			prev_prev_sum <= '1;
		end else if (enable && step_in) begin
			if (window_end) begin
				win_idx <= '0;
				cur_sum <= '0;
				prev_sum <= sum_next; // shift the energy history
				prev_prev_sum <= prev_sum;
			end else begin
				win_idx <= win_idx + 1'b1;
				cur_sum <= sum_next;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/sos_dist_calculator.sv */
`default_nettype none

// runs measurement rounds until three rounds agree on the echo delay
module sos_dist_calculator import audio_pkg::*, ranging_pkg::*; #(
	parameter int WINDOW_SIZE = 16
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic trigger,
	input logic signed [SAMPLE_W-1:0] mic_in,
	output logic signed [SAMPLE_W-1:0] amp_out,
	output logic [DELAY_W-1:0] delay, // in 24 kHz samples
	output logic delay_valid,
	output logic [23:0] last_two
);

	ranger_state_t state;

	logic impulse_in;
	logic impulse_out;
	logic det_clear;
	logic det_enable;
	logic window_end;
	logic onset;

	logic [DELAY_W-1:0] sample_cnt; // samples since click start
	logic [DELAY_W-1:0] next_cnt;
	logic [DELAY_W-1:0] last_cand; // 0 means no candidate yet
	logic [DELAY_W-1:0] prev_cand;
	logic [$clog2(REARM_STEPS)-1:0] rearm_cnt;

	assign impulse_in = (state == START);
	assign det_clear = (state == AWAIT_CLICK) && impulse_out;
	assign det_enable = (state == ANALYZE);
	assign next_cnt = sample_cnt + 1'b1;

	impulse_generator imp_gen (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.impulse_in(impulse_in),
		.impulse_out(impulse_out),
		.amp_out(amp_out)
	);

	onset_detector #(
		.WINDOW_SIZE(WINDOW_SIZE)
	) onset_det (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.clear(det_clear),
		.enable(det_enable),
		.mic_in(mic_in),
		.window_end(window_end),
		.onset(onset)
	);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= IDLE;
			delay_valid <= 1'b0;
			sample_cnt <= '0;
			last_cand <= '0;
			prev_cand <= '0;
			rearm_cnt <= '0;
			last_two <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (trigger) begin
						last_cand <= '0; // forget old candidates
						prev_cand <= '0;
						state <= START;
					end
				end
				START: begin
					delay_valid <= 1'b0;
					rearm_cnt <= '0;
					state <= AWAIT_CLICK;
				end
				AWAIT_CLICK: begin
					if (impulse_out) begin
						sample_cnt <= '0;
						state <= ANALYZE;
					end
				end
				ANALYZE: begin
					if (step_in) begin
						sample_cnt <= next_cnt;
						if (window_end) begin
							last_two <= {next_cnt, last_cand};
						end
						if (onset) begin
							prev_cand <= last_cand;
							last_cand <= next_cnt;
							// candidate never equals 0, so stale slots never match
							if (next_cnt == last_cand && next_cnt == prev_cand) begin
								delay <= next_cnt;
								delay_valid <= 1'b1;
								state <= IDLE;
							end else begin
								state <= REARM;
							end
						end else if (next_cnt == DELAY_W'(MAX_DELAY)) begin
							last_two <= SENTINEL_PAIR; // no echo this round
							state <= REARM;
						end
					end
				end
				REARM: begin
					if (step_in) begin
						if (rearm_cnt == $bits(rearm_cnt)'(REARM_STEPS - 1)) begin
							state <= START;
						end else begin
							rearm_cnt <= rearm_cnt + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/distance_converter.sv */
`default_nettype none

module distance_converter import ranging_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic delay_valid,
	input logic [DELAY_W-1:0] delay,
	output logic [DIST_W-1:0] distance_cm,
	output logic distance_valid
);

	logic [DELAY_W+7:0] scaled; // Q8 centimetres

	assign scaled = delay * CM_PER_STEP_Q8;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			distance_valid <= 1'b0;
		end else begin
			distance_valid <= delay_valid;
		end
	end

	// drop the fraction bits
	always_ff @(posedge clk_in) begin
		distance_cm <= DIST_W'(scaled[DELAY_W+7:8]);
	end

endmodule

`default_nettype wire

/* hdl/sos_ranger.sv */
`default_nettype none

module sos_ranger import audio_pkg::*, ranging_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic step_in, // one strobe per 24 kHz sample
	input logic trigger,
	input logic signed [SAMPLE_W-1:0] mic_in,
	output logic signed [SAMPLE_W-1:0] amp_out, // speaker sample
	output logic [DELAY_W-1:0] delay,
	output logic delay_valid,
	output logic [23:0] last_two,
	output logic [DIST_W-1:0] distance_cm,
	output logic distance_valid
);

	sos_dist_calculator dist_calc (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.trigger(trigger),
		.mic_in(mic_in),
		.amp_out(amp_out),
		.delay(delay),
		.delay_valid(delay_valid),
		.last_two(last_two)
	);

	// delay in samples to centimetres
	distance_converter dist_conv (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.delay_valid(delay_valid),
		.delay(delay),
		.distance_cm(distance_cm),
		.distance_valid(distance_valid)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk_in,
	output logic rst_in
);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in; // period 8
	end

	initial begin
		rst_in = 1'b1;
		repeat (3) @(posedge clk_in);
		#1 rst_in = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`default_nettype none

// watches the DUT outputs, keeps error counts and reports each test
module tb_checker import audio_pkg::*, ranging_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic signed [SAMPLE_W-1:0] amp_out,
	input logic [DELAY_W-1:0] delay,
	input logic delay_valid,
	input logic [23:0] last_two,
	input logic [DIST_W-1:0] distance_cm,
	input logic distance_valid
);

	int click_count = 0; // clicks seen on amp_out
	int mon_errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;
	int run_len = 0; // samples of the current click
	logic signed [SAMPLE_W-1:0] prev_amp = '0;

	// click shape monitor on the falling edge
	always @(negedge clk_in) begin
		if (rst_in) begin
			prev_amp = '0;
			run_len = 0;
		end else if (amp_out != prev_amp) begin
			if (prev_amp == 0) begin
				click_count++;
				run_len = 1;
				if (amp_out != IMPULSE_AMP) begin
					$display("ERROR amp_out got %h expected %h", amp_out, IMPULSE_AMP);
					mon_errors++;
				end
			end else if (amp_out == 0) begin
				if (run_len != IMPULSE_LEN) begin
					$display("ERROR click_length got %h expected %h", run_len, IMPULSE_LEN);
					mon_errors++;
				end
			end else begin
				run_len++;
				if (amp_out != -prev_amp) begin // sign must alternate
					$display("ERROR amp_out got %h expected %h", amp_out, -prev_amp);
					mon_errors++;
				end
			end
			prev_amp = amp_out;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_fail(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	// quiet is cleared when any output is active
	task automatic check_quiet(output bit quiet);
		int errs;
		errs = test_errors;
		check_value("delay_valid", 32'(delay_valid), 32'd0);
		check_value("distance_valid", 32'(distance_valid), 32'd0);
		check_value("amp_out", 32'(amp_out), 32'd0);
		quiet = (test_errors == errs);
	endtask

	task automatic check_delay(input int exp);
		check_value("delay", 32'(delay), 32'(exp));
	endtask

	task automatic check_distance(input int exp);
		check_value("distance_cm", 32'(distance_cm), 32'(exp));
	endtask

	// a timed out round leaves the sentinel until the next window end
	task automatic check_round_timeout();
		check_value("last_two", 32'(last_two), 32'(SENTINEL_PAIR));
		check_value("delay_valid", 32'(delay_valid), 32'd0);
	endtask

	task automatic start_test();
		errors_at_start = test_errors + mon_errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors + mon_errors != errors_at_start) begin
			tests_failed++;
			$display("test %s failed", name);
		end else begin
			$display("test %s passed", name);
		end
	endtask

	function automatic int error_total();
		return test_errors + mon_errors;
	endfunction

	task automatic report_counts();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			test_errors + mon_errors);
	endtask

endmodule

`default_nettype wire

/* testbench/tb_sos_ranger.sv */
`default_nettype none

module tb_sos_ranger import audio_pkg::*, ranging_pkg::*; ;

	localparam int WINDOW = 16;
	localparam int STEP_DIV = 4; // clocks per sample strobe
	localparam int NUM_ENTRIES = 5;
	// echo start, burst length and amplitude per entry
	// silent entries use the background as echo
	localparam int TAB_D[NUM_ENTRIES] = '{40, 100, 300, 200, 0};
	localparam int TAB_L[NUM_ENTRIES] = '{20, 8, 30, 12, 0};
	localparam int TAB_A[NUM_ENTRIES] = '{3000, -2500, 1200, 800, 0};
	localparam bit TAB_SILENT[NUM_ENTRIES] = '{0, 0, 0, 0, 1};

	logic clk_in;
	logic rst_in;
	logic step_in = 1'b0;
	logic trigger = 1'b0;
	logic signed [SAMPLE_W-1:0] mic_in = '0;
	logic signed [SAMPLE_W-1:0] amp_out;
	logic [DELAY_W-1:0] delay;
	logic delay_valid;
	logic [23:0] last_two;
	logic [DIST_W-1:0] distance_cm;
	logic distance_valid;

	int cur_d = 0;
	int cur_l = 0;
	int cur_a = 0;
	int cur_b = 0;
	int samp_cnt = 100000; // far from any echo until the first click
	int phase = 0;
	logic signed [SAMPLE_W-1:0] prev_amp_seen = '0;
	logic [31:0] lfsr_state = 32'h188d;

	tb_clock clk0 (.clk_in(clk_in), .rst_in(rst_in));

	sos_ranger dut0 (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.trigger(trigger),
		.mic_in(mic_in),
		.amp_out(amp_out),
		.delay(delay),
		.delay_valid(delay_valid),
		.last_two(last_two),
		.distance_cm(distance_cm),
		.distance_valid(distance_valid)
	);

	tb_checker chk0 (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.amp_out(amp_out),
		.delay(delay),
		.delay_valid(delay_valid),
		.last_two(last_two),
		.distance_cm(distance_cm),
		.distance_valid(distance_valid)
	);

	function automatic int sample_value(input int n, input int d, input int l, input int a,
		input int b);
		return (n >= d && n < d + l) ? a : b;
	endfunction

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// onset rule applied to the echo model, 0 when no window qualifies
	function automatic int expected_delay(input int d, input int l, input int a, input int b);
		longint e;
		longint e_p;
		longint e_pp;
		bit have_p;
		bit have_pp;
		e_p = 0;
		e_pp = 0;
		have_p = 0;
		have_pp = 0;
		for (int j = 0; (j + 1) * WINDOW <= MAX_DELAY; j++) begin
			e = 0;
			for (int n = j * WINDOW + 1; n <= (j + 1) * WINDOW; n++)
				e += abs_int(sample_value(n, d, l, a, b));
			if (have_p && have_pp && e > e_p && e > e_pp + e_pp / 4)
				return (j + 1) * WINDOW;
			e_pp = e_p;
			have_pp = have_p;
			e_p = e;
			have_p = 1;
		end
		return 0;
	endfunction

	// fibonacci lfsr with taps 32 22 2 1
	task automatic draw_bits(input int n, output int val);
		logic fb;
		val = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = (val << 1) | int'(fb);
		end
	endtask

	// sample strobe and echo model
	always @(posedge clk_in) begin
		#1;
		if (rst_in) begin
			step_in = 1'b0;
			phase = 0;
			prev_amp_seen = '0;
		end else begin
			if (prev_amp_seen == 0 && amp_out != 0)
				samp_cnt = 0; // click start is the delay origin
			prev_amp_seen = amp_out;
			phase = (phase + 1) % STEP_DIV;
			step_in = (phase == 0);
			if (step_in) begin
				samp_cnt++;
				mic_in = 16'(sample_value(samp_cnt, cur_d, cur_l, cur_a, cur_b));
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk_in);
		#1;
	endtask

	task automatic pulse_trigger();
		trigger = 1'b1;
		next_cycle();
		trigger = 1'b0;
	endtask

	task automatic wait_for_click(input int limit, output bit ok);
		int c0;
		c0 = chk0.click_count;
		ok = 0;
		for (int i = 0; i < limit && !ok; i++) begin
			next_cycle();
			ok = (chk0.click_count != c0);
		end
	endtask

	task automatic wait_amp_silent(input int limit, output bit ok);
		ok = 0;
		for (int i = 0; i < limit && !ok; i++) begin
			next_cycle();
			ok = (amp_out == 0);
		end
	endtask

	task automatic wait_delay_valid(input int limit, output bit ok);
		ok = 0;
		for (int i = 0; i < limit && !ok; i++) begin
			next_cycle();
			ok = delay_valid;
		end
	endtask

	task automatic wait_distance_valid(input int limit, output bit ok);
		ok = distance_valid;
		for (int i = 0; i < limit && !ok; i++) begin
			next_cycle();
			ok = distance_valid;
		end
	endtask

	task automatic run_echo(input int e, input int exp_delay);
		int clicks0;
		int exp_dist;
		bit ok;
		string name;
		name = $sformatf("echo_%0d", e);
		exp_dist = (exp_delay * 183) >> 8;
		clicks0 = chk0.click_count;
		chk0.start_test();
		pulse_trigger();
		wait_for_click(40, ok);
		if (!ok)
			chk0.check_fail($sformatf("no click after trigger in test %s", name));
		if (e == 0) begin
			wait_amp_silent(40, ok);
			if (!ok)
				chk0.check_fail("click did not return to silence");
			chk0.check_value("click_count", 32'(chk0.click_count - clicks0), 32'd1);
			chk0.end_test("click_shape");
			chk0.start_test();
		end
		repeat (60) next_cycle();
		pulse_trigger(); // must be ignored mid measurement
		wait_delay_valid(12000, ok);
		if (!ok) begin
			chk0.check_fail($sformatf("timeout waiting for delay_valid in test %s", name));
		end else begin
			chk0.check_delay(exp_delay);
			wait_distance_valid(4, ok);
			if (!ok)
				chk0.check_fail($sformatf("distance_valid never followed in test %s", name));
			else
				chk0.check_distance(exp_dist);
			chk0.check_value("click_count", 32'(chk0.click_count - clicks0), 32'd3);
		end
		chk0.end_test(name);
	endtask

	task automatic run_no_echo(input int e);
		int clicks0;
		bit ok;
		string name;
		name = $sformatf("no_echo_%0d", e);
		clicks0 = chk0.click_count;
		chk0.start_test();
		pulse_trigger();
		wait_for_click(40, ok);
		if (!ok)
			chk0.check_fail($sformatf("no click after trigger in test %s", name));
		// each later click opens a round after a timed out one
		for (int r = 1; r <= 3 && ok; r++) begin
			wait_for_click(3000, ok);
			if (!ok) begin
				chk0.check_fail($sformatf("next round never started in test %s", name));
			end else begin
				chk0.check_round_timeout();
				chk0.check_value("click_count", 32'(chk0.click_count - clicks0), 32'(r + 1));
			end
		end
		chk0.end_test(name);
	endtask

	initial begin
		int b;
		int exp_delay;
		bit quiet;
		chk0.start_test();
		for (int i = 0; i < 20 && rst_in !== 1'b0; i++)
			next_cycle();
		if (rst_in !== 1'b0)
			chk0.check_fail("reset was never released");
		quiet = 1;
		for (int i = 0; i < 200 && quiet; i++) begin
			next_cycle();
			chk0.check_quiet(quiet);
		end
		chk0.check_value("click_count", 32'(chk0.click_count), 32'd0);
		chk0.end_test("reset_idle");
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			draw_bits(4, b); // small background level
			cur_b = b;
			cur_d = TAB_D[e];
			cur_l = TAB_L[e];
			cur_a = TAB_SILENT[e] ? b : TAB_A[e];
			exp_delay = expected_delay(cur_d, cur_l, cur_a, cur_b);
			if (exp_delay == 0)
				run_no_echo(e);
			else
				run_echo(e, exp_delay);
		end
		chk0.report_counts();
		if (chk0.error_total() == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// overall limit on simulation time
	initial begin
		#400000;
		$display("simulation did not finish within its time limit");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/audio_pkg.sv
hdl/ranging_pkg.sv
hdl/impulse_generator.sv
hdl/onset_detector.sv
hdl/sos_dist_calculator.sv
hdl/distance_converter.sv
hdl/sos_ranger.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_sos_ranger.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
TOP ?= tb_sos_ranger
RTL_TOP ?= sos_ranger
FLIST ?= flist.f
LOG ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
